// File: hdl/uart_rx_pkg.sv
// assumes power-of-two channel count and buffer depth; widths below must match the counts
`default_nettype none

package uart_rx_pkg;

    // channel setup
    localparam int NUM_CH = 4;        // receive channels on the hub
    localparam int CH_W   = 2;        // bits in a channel index

    // shared buffer sizing
    localparam int FIFO_DEPTH = 16;   // entries in the shared receive buffer
    localparam int PTR_W      = 4;    // buffer pointer width, log2 of depth

    // bit period divisor, clocks per bit minus one
    localparam int BAUD_W = 16;

    // receiver FSM, same encoding as the single-channel receiver
    typedef enum logic [1:0] {
        IDLE      = 2'd0,   // line idle, waiting for a falling edge
        START_BIT = 2'd1,   // half-bit wait, then start bit recheck
        DATA_BITS = 2'd2,   // eight data bits, lsb first
        STOP_BIT  = 2'd3    // stop bit must sample high
    } rx_state_e;

    // one buffer entry, 11 bits
    typedef struct packed {
        logic [CH_W-1:0] ch;       // channel that delivered the byte
        logic            overrun;  // later bytes of this channel were lost
        logic [7:0]      data;     // received byte
    } rx_entry_t;

endpackage : uart_rx_pkg

`default_nettype wire

// File: hdl/uart_rx_core.sv
// 8N1 only, rx_pin must already be synchronous to clk; bad stop bit drops the byte silently
`timescale 1ns/1ns
`default_nettype none

module uart_rx_core (
    input  wire                         clk,
    input  wire                         rst_n,     // sync, active low
    input  wire [uart_rx_pkg::CH_W-1:0] ch_id,     // tag for entries from this core
    input  wire [uart_rx_pkg::BAUD_W-1:0] baud_div, // clocks per bit minus one
    input  wire                         rx_pin,    // serial line, idles high
    input  wire                         grant,     // entry taken by the buffer this cycle
    output logic                        hold,      // entry is valid and waiting
    output uart_rx_pkg::rx_entry_t      entry      // holding register
);
    import uart_rx_pkg::*;

    rx_state_e         state;
    logic [BAUD_W-1:0] bit_timer;   // counts down to the next sample point
    logic [2:0]        bit_index;   // data bit being sampled
    logic [7:0]        shift_byte;  // byte under assembly

    logic stop_ok;   // good stop bit sampled on this edge

    // stop sample point with the line high
    assign stop_ok = (state == STOP_BIT) && (bit_timer == '0) && rx_pin;

    // bit timing FSM, count-to-zero like the single-channel receiver
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            bit_timer <= '0;
            bit_index <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!rx_pin) begin                 // falling edge, maybe a start bit
                        state     <= START_BIT;
                        bit_timer <= baud_div >> 1;    // wait to mid start bit
                        bit_index <= '0;
                    end
                end

                START_BIT: begin
                    if (bit_timer == '0) begin
                        if (!rx_pin) begin             // still low, real start bit
                            state     <= DATA_BITS;
                            bit_timer <= baud_div;
                            bit_index <= '0;
                        end else begin
                            state <= IDLE;             // glitch, ignore it
                        end
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                DATA_BITS: begin
                    if (bit_timer == '0) begin
                        bit_timer <= baud_div;         // next mid-bit
                        if (bit_index == 3'd7)
                            state <= STOP_BIT;
                        else
                            bit_index <= bit_index + 1'b1;
                    end else begin
                        bit_timer <= bit_timer - 1'b1;
                    end
                end

                STOP_BIT: begin
                    if (bit_timer == '0)
                        state <= IDLE;                 // good or bad, back to idle
                    else
                        bit_timer <= bit_timer - 1'b1;
                end

                default: state <= IDLE;
            endcase
        end
    end

    // data shifter, sampled at mid-bit
    always_ff @(posedge clk) begin
        if (state == START_BIT && bit_timer == '0)
            shift_byte <= '0;
        else if (state == DATA_BITS && bit_timer == '0)
            shift_byte[bit_index] <= rx_pin;   // lsb arrives first
    end

    // hold flag
    // a byte finishing on the grant cycle refills the register, so hold stays up
    always_ff @(posedge clk) begin
        if (!rst_n)
            hold <= 1'b0;
        else if (stop_ok)
            hold <= 1'b1;
        else if (grant)
            hold <= 1'b0;   // entry left for the buffer
    end

    // holding register payload
    always_ff @(posedge clk) begin
        if (stop_ok) begin
            if (!hold || grant) begin
                entry.ch      <= ch_id;
                entry.overrun <= 1'b0;
                entry.data    <= shift_byte;
            end else begin
                entry.overrun <= 1'b1;   // register busy, new byte is lost
            end
        end
    end

endmodule : uart_rx_core

`default_nettype wire

// File: hdl/rx_write_arbiter.sv
// channel count must be a power of two so the rotating index wraps by truncation
`timescale 1ns/1ns
`default_nettype none

module rx_write_arbiter (
    input  wire                           clk,
    input  wire                           rst_n,   // sync, active low
    input  wire [uart_rx_pkg::NUM_CH-1:0] hold,    // channels with a waiting entry
    input  wire                           full,    // buffer cannot take a write
    output logic [uart_rx_pkg::NUM_CH-1:0] grant,  // one-hot, single cycle
    output logic [uart_rx_pkg::CH_W-1:0]   wr_sel  // index of the granted channel
);
    import uart_rx_pkg::*;

    logic [CH_W-1:0] ptr;   // highest priority channel this cycle

    // rotating priority search starting at ptr
    always_comb begin
        logic [CH_W-1:0] idx;
        logic            found;
        grant  = '0;
        wr_sel = ptr;        // don't care without a grant
        found  = 1'b0;
        for (int i = 0; i < NUM_CH; i++) begin
            idx = ptr + CH_W'(i);   // wraps past the last channel
            if (!found && !full && hold[idx]) begin
                grant[idx] = 1'b1;
                wr_sel     = idx;
                found      = 1'b1;
            end
        end
    end

    // priority moves to the channel after the winner
    always_ff @(posedge clk) begin
        if (!rst_n)
            ptr <= '0;
        else if (|grant)
            ptr <= wr_sel + 1'b1;
    end

endmodule : rx_write_arbiter

`default_nettype wire

// File: hdl/rx_entry_fifo.sv
// wr_en is trusted and must never be high while full; rd_entry is combinational from the array
`timescale 1ns/1ns
`default_nettype none

module rx_entry_fifo (
    input  wire                          clk,
    input  wire                          rst_n,     // sync, active low
    input  wire                          wr_en,     // write strobe, never while full
    input  wire uart_rx_pkg::rx_entry_t  wr_entry,
    input  wire                          rd_en,     // pop request
    output logic                         full,
    output logic                         rd_valid,  // buffer not empty
    output uart_rx_pkg::rx_entry_t       rd_entry   // oldest entry
);
    import uart_rx_pkg::*;

    rx_entry_t        mem [FIFO_DEPTH];   // entry storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;              // 0 to FIFO_DEPTH inclusive

    logic pop;   // accepted read

    assign pop      = rd_en && rd_valid;   // rd_en on empty is ignored
    assign full     = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign rd_valid = (count != '0);
    assign rd_entry = mem[rd_ptr];

    // storage write
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= wr_entry;
    end

    // pointers wrap naturally at the power of two depth
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // occupancy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle, or write and pop together
            endcase
        end
    end

endmodule : rx_entry_fifo

`default_nettype wire

// File: hdl/uart_rx_hub.sv
// all channels share one baud_div; pins are sampled as-is, no synchronizer inside
`timescale 1ns/1ns
`default_nettype none

module uart_rx_hub (
    input  wire                             clk,
    input  wire                             rst_n,     // sync, active low
    input  wire [uart_rx_pkg::BAUD_W-1:0]   baud_div,  // shared bit period
    input  wire [uart_rx_pkg::NUM_CH-1:0]   rx_pin,    // one serial line per channel
    input  wire                             rd_en,     // host pop
    output logic                            rd_valid,  // entry available
    output uart_rx_pkg::rx_entry_t          rd_entry   // oldest entry
);
    import uart_rx_pkg::*;

    logic [NUM_CH-1:0] hold;               // per channel entry waiting
    logic [NUM_CH-1:0] grant;              // one-hot write grant
    logic [CH_W-1:0]   wr_sel;             // winning channel
    rx_entry_t         ch_entry [NUM_CH];  // holding registers
    rx_entry_t         wr_entry;
    logic              wr_en;
    logic              full;

    // one receiver per channel
    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        uart_rx_core u_core (
            .clk      (clk),
            .rst_n    (rst_n),
            .ch_id    (CH_W'(i)),
            .baud_div (baud_div),
            .rx_pin   (rx_pin[i]),
            .grant    (grant[i]),
            .hold     (hold[i]),
            .entry    (ch_entry[i])
        );
    end

    rx_write_arbiter u_arb (
        .clk    (clk),
        .rst_n  (rst_n),
        .hold   (hold),
        .full   (full),
        .grant  (grant),
        .wr_sel (wr_sel)
    );

    assign wr_entry = ch_entry[wr_sel];   // winner's entry
    assign wr_en    = |grant;             // grant pulse is the write strobe

    rx_entry_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_entry (wr_entry),
        .rd_en    (rd_en),
        .full     (full),
        .rd_valid (rd_valid),
        .rd_entry (rd_entry)
    );

endmodule : uart_rx_hub

`default_nettype wire

// File: verif/uart_rx_hub_chk.sv
// bound into uart_rx_hub; assumes rst_n is released on a clock edge, as the hub's reset is synchronous
`timescale 1ns/1ns
`default_nettype none

module uart_rx_hub_chk (
    input wire                           clk,
    input wire                           rst_n,
    input wire [uart_rx_pkg::NUM_CH-1:0] grant,     // arbiter output
    input wire                           wr_en,     // buffer write strobe
    input wire                           full,      // buffer full level
    input wire                           rd_valid   // host side valid
);

    // at most one channel wins a cycle
    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
        else $error("grant not zero or one-hot: %b", grant);

    // the buffer trusts wr_en, so a write on full would corrupt it
    a_no_write_full: assert property (@(posedge clk) disable iff (!rst_n)
        full |-> !wr_en)
        else $error("buffer write while full");

    // first cycle out of reset
    a_reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> (!rd_valid && (grant == '0)))
        else $error("rd_valid or grant high right after reset, grant %b", grant);

endmodule : uart_rx_hub_chk

bind uart_rx_hub uart_rx_hub_chk u_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .grant    (grant),
    .wr_en    (wr_en),
    .full     (full),
    .rd_valid (rd_valid)
);

`default_nettype wire

// File: verif/uart_rx_hub_tb.sv
// pins are driven synchronously on clk; stops at the first mismatch; seed is fixed at 24
`timescale 1ns/1ns
`default_nettype none

module uart_rx_hub_tb;
    import uart_rx_pkg::*;

    localparam int MAX_DIV     = 20;    // largest divisor any phase may pick
    localparam int N_FRAMES    = 70;    // frames over all phases, rounded up
    localparam int CLK_NS      = 20;
    localparam int WATCHDOG_NS = N_FRAMES * 11 * (MAX_DIV + 1) * CLK_NS + 100_000;
    localparam int DRAIN_LIMIT = 2000;  // cycles allowed for the host to empty the buffer

    logic              clk;
    logic              rst_n;
    logic [BAUD_W-1:0] baud_div;
    logic [NUM_CH-1:0] rx_pin;
    logic              rd_en;
    logic              rd_valid;
    rx_entry_t         rd_entry;

    // reference model
    rx_entry_t exp_q [NUM_CH][$];         // expected entries per channel, in send order
    rx_entry_t order_q [$];               // exact pop order, stall phase only
    rx_entry_t held_entry [NUM_CH];       // modeled holding registers
    logic      held_valid [NUM_CH];
    logic      strict_order = 1'b0;       // pops follow order_q instead of exp_q
    int        rd_mode      = 0;          // 0 no reads, 1 read every cycle, 2 random reads
    int        pop_total    = 0;          // entries popped so far

    uart_rx_hub UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .baud_div (baud_div),
        .rx_pin   (rx_pin),
        .rd_en    (rd_en),
        .rd_valid (rd_valid),
        .rd_entry (rd_entry)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;   // 20 ns period

    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_entry(input rx_entry_t want, input rx_entry_t got);
        if (got !== want) begin
            $display("[ERROR] rd_entry expected 0x%03h got 0x%03h", want, got);
            $display("        ch %0h/%0h overrun %0h/%0h data 0x%02h/0x%02h",
                     want.ch, got.ch, want.overrun, got.overrun, want.data, got.data);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input logic [PTR_W:0] want,
                               input logic [PTR_W:0] got);
        if (got !== want) begin
            $display("[ERROR] %s expected 0x%0h got 0x%0h", name, want, got);
            abort_run();
        end
    endtask

    task automatic check_level(input string name, input logic want, input logic got);
        if (got !== want) begin
            $display("[ERROR] %s expected 0x%0h got 0x%0h", name, want, got);
            abort_run();
        end
    endtask

    function automatic rx_entry_t make_entry(input int ch, input logic [7:0] data);
        rx_entry_t e;
        e.ch      = CH_W'(ch);
        e.overrun = 1'b0;
        e.data    = data;
        return e;
    endfunction

    function automatic logic model_empty();
        logic empty;
        empty = (order_q.size() == 0);
        for (int c = 0; c < NUM_CH; c++)
            if (exp_q[c].size() != 0)
                empty = 1'b0;
        return empty;
    endfunction

    // start, eight data bits lsb first, stop, then one idle bit
    task automatic send_frame(input int ch, input logic [7:0] data, input logic stop_val);
        int         bit_cycles;
        logic [9:0] frame;
        bit_cycles = int'(baud_div) + 1;   // count-to-zero gives divisor plus one
        frame      = {stop_val, data, 1'b0};
        @(posedge clk);
        for (int b = 0; b < 10; b++) begin
            rx_pin[ch] <= frame[b];
            repeat (bit_cycles) @(posedge clk);
        end
        rx_pin[ch] <= 1'b1;
        repeat (bit_cycles) @(posedge clk);
    endtask

    task automatic send_glitch(input int ch, input int len);
        @(posedge clk);
        rx_pin[ch] <= 1'b0;
        repeat (len) @(posedge clk);
        rx_pin[ch] <= 1'b1;
    endtask

    // several good frames after a random start delay
    task automatic send_burst(input int ch);
        logic [7:0] byte_val;
        repeat ($urandom_range(3 * MAX_DIV)) @(posedge clk);
        for (int k = 0; k < 6; k++) begin
            byte_val = 8'($urandom);
            exp_q[ch].push_back(make_entry(ch, byte_val));
            send_frame(ch, byte_val, 1'b1);
        end
    endtask

    task automatic new_baud();
        @(posedge clk);
        baud_div <= BAUD_W'($urandom_range(MAX_DIV, 6));
        @(posedge clk);
    endtask

    // done when the model expects nothing more and the buffer is empty
    task automatic wait_drained();
        int n;
        n = 0;
        @(negedge clk);
        while (!model_empty() || rd_valid) begin
            @(negedge clk);
            n++;
            if (n > DRAIN_LIMIT) begin
                $display("timeout: buffer did not drain, %0d entries still expected",
                         order_q.size() + exp_q[0].size() + exp_q[1].size()
                         + exp_q[2].size() + exp_q[3].size());
                abort_run();
            end
        end
    endtask

    // done once rd_valid drops, whatever the model still expects
    task automatic wait_buffer_empty();
        int n;
        n = 0;
        @(negedge clk);
        while (rd_valid) begin
            @(negedge clk);
            n++;
            if (n > DRAIN_LIMIT) begin
                $display("timeout: buffer still not empty after %0d cycles", DRAIN_LIMIT);
                abort_run();
            end
        end
    endtask

    // host read enable, the only driver of rd_en
    initial begin
        rd_en = 1'b0;
        forever begin
            @(posedge clk);
            case (rd_mode)
                1:       rd_en <= 1'b1;
                2:       rd_en <= 1'($urandom);
                default: rd_en <= 1'b0;
            endcase
        end
    end

    // a pop is decided here and taken on the next rising edge
    always @(negedge clk) begin
        rx_entry_t want;
        if (rst_n && rd_en && rd_valid) begin
            if (strict_order && order_q.size() == 0) begin
                $display("unexpected entry popped in stall phase: 0x%03h", rd_entry);
                abort_run();
            end else if (!strict_order && exp_q[rd_entry.ch].size() == 0) begin
                $display("unexpected entry popped for channel %0d: 0x%03h",
                         rd_entry.ch, rd_entry);
                abort_run();
            end else begin
                want = strict_order ? order_q.pop_front() : exp_q[rd_entry.ch].pop_front();
                check_entry(want, rd_entry);
                pop_total <= pop_total + 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run took longer than its frame budget allows");
        abort_run();
    end

    initial begin
        int         ch;
        int         glen;
        int         start_pops;
        int         next_ptr;
        int         buffered;
        logic [7:0] byte_val;
        rx_entry_t  e;

        void'($urandom(24));
        rst_n    = 1'b0;
        baud_div = BAUD_W'(MAX_DIV);
        rx_pin   = '1;            // idle lines
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        $display("phase 1: one channel at a time");
        new_baud();
        rd_mode = 1;
        for (int c = 0; c < NUM_CH; c++) begin
            for (int k = 0; k < 3; k++) begin
                byte_val = 8'($urandom);
                exp_q[c].push_back(make_entry(c, byte_val));
                send_frame(c, byte_val, 1'b1);
            end
        end
        wait_drained();

        $display("phase 2: all channels at once, random reads");
        new_baud();
        rd_mode = 2;
        fork
            send_burst(0);
            send_burst(1);
            send_burst(2);
            send_burst(3);
        join
        rd_mode = 1;
        wait_drained();

        $display("phase 3: glitch on an idle line");
        new_baud();
        ch   = int'($urandom_range(NUM_CH - 1));
        glen = int'($urandom_range((int'(baud_div) >> 1) - 1, 1));   // under half a bit
        send_glitch(ch, glen);
        repeat (3 * (int'(baud_div) + 1)) begin
            @(negedge clk);
            check_level("rd_valid", 1'b0, rd_valid);
        end
        byte_val = 8'($urandom);
        exp_q[ch].push_back(make_entry(ch, byte_val));
        send_frame(ch, byte_val, 1'b1);
        wait_drained();

        $display("phase 4: low stop bit");
        new_baud();
        ch       = int'($urandom_range(NUM_CH - 1));
        byte_val = 8'($urandom);
        send_frame(ch, byte_val, 1'b0);   // dropped by the receiver
        byte_val = ~byte_val;              // good frame differs from the dropped one
        exp_q[ch].push_back(make_entry(ch, byte_val));
        send_frame(ch, byte_val, 1'b1);
        wait_drained();

        $display("phase 5: back-pressure and overrun");
        rd_mode      = 0;
        strict_order = 1'b1;
        new_baud();
        buffered = 0;
        next_ptr = 0;
        for (int c = 0; c < NUM_CH; c++)
            held_valid[c] = 1'b0;
        for (int k = 0; k < FIFO_DEPTH + 10; k++) begin
            ch       = int'($urandom_range(NUM_CH - 1));
            byte_val = 8'($urandom);
            e        = make_entry(ch, byte_val);
            if (buffered < FIFO_DEPTH) begin        // granted straight into the buffer
                order_q.push_back(e);
                buffered++;
                next_ptr = (ch + 1) % NUM_CH;       // priority moves past the winner
            end else if (!held_valid[ch]) begin     // buffer full, channel keeps it
                held_valid[ch] = 1'b1;
                held_entry[ch] = e;
            end else begin
                held_entry[ch].overrun = 1'b1;      // new byte lost behind the held one
            end
            send_frame(ch, byte_val, 1'b1);
        end
        // held entries leave in rotating order from the pointer
        for (int i = 0; i < NUM_CH; i++) begin
            ch = (next_ptr + i) % NUM_CH;
            if (held_valid[ch]) begin
                order_q.push_back(held_entry[ch]);
                buffered++;                         // held ones come out after the buffer
            end
        end
        @(negedge clk);
        check_level("rd_valid", 1'b1, rd_valid);
        start_pops = pop_total;
        rd_mode    = 1;
        wait_buffer_empty();
        repeat (2) @(negedge clk);
        check_count("pop_total", (PTR_W+1)'(buffered), (PTR_W+1)'(pop_total - start_pops));
        check_level("rd_valid", 1'b0, rd_valid);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule : uart_rx_hub_tb

`default_nettype wire

// File: vlog.f
hdl/uart_rx_pkg.sv
hdl/uart_rx_core.sv
hdl/rx_write_arbiter.sv
hdl/rx_entry_fifo.sv
hdl/uart_rx_hub.sv
verif/uart_rx_hub_chk.sv
verif/uart_rx_hub_tb.sv

// File: Makefile
# Verilator build and run for the four-channel receive hub

VERILATOR ?= verilator
TOP       ?= uart_rx_hub_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)" || { echo "simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)
